/* source/sta_pkg.sv */
package sta_pkg;

  typedef logic signed [7:0]  int8_t;   // Activation / weight value
  typedef logic signed [31:0] int32_t;  // Accumulator value

  localparam int SA_N       = 4;  // Array is SA_N x SA_N PEs
  localparam int VEC_W      = 4;  // Dot-product terms per PE per cycle
  localparam int NUM_LAYERS = 8;  // Entries in the requant table

  // Per-layer requantization multiplier
  localparam logic signed [15:0] layer_scale [NUM_LAYERS] = '{
    16'sd1, 16'sd3, 16'sd7, -16'sd5, 16'sd1024, 16'sd255, -16'sd128, 16'sd32767
  };

  // Per-layer arithmetic right shift applied after the multiply
  localparam logic [4:0] layer_shift [NUM_LAYERS] = '{
    5'd0, 5'd2, 5'd4, 5'd3, 5'd12, 5'd8, 5'd6, 5'd20
  };

  // One A row or B column vector, element 0 in the low byte
  typedef struct packed {
    int8_t [VEC_W-1:0] v;
  } sta_vec_t;

  // One drained array row, data[j] is column j
  typedef struct packed {
    logic                valid;
    logic [1:0]          row;   // Local row within the block
    int32_t [SA_N-1:0]   data;
  } acc_row_t;

  // One requantized row
  typedef struct packed {
    logic               valid;
    logic [1:0]         row;
    int8_t [SA_N-1:0]   data;
  } q_row_t;

  // One pooled row of the 2x2 result
  typedef struct packed {
    logic         valid;
    logic         row;    // Pooled row, local row / 2
    int8_t [1:0]  data;   // data[c] is pooled column c
  } pool_row_t;

  typedef enum logic {OC_IDLE, OC_DRAIN} oc_state_e;

  typedef enum logic {BUF_POOL, BUF_BYPASS} buf_mode_e;

endpackage

/* source/systolic_tensor_array.sv */
`timescale 1ns/10ps

module systolic_tensor_array import sta_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     in_valid,
  input  sta_vec_t a_in [SA_N],       // One vector per array row
  input  sta_vec_t b_in [SA_N],       // One vector per array column
  input  logic     load_bias,
  input  int32_t   bias_value,        // Shared by all 16 PEs
  output int32_t   acc [SA_N][SA_N],
  output logic     sta_idle
);

  logic [SA_N*SA_N-1:0] pe_valid;  // Product stage occupancy, one bit per PE

  for (genvar i = 0; i < SA_N; i++) begin : g_row
    for (genvar j = 0; j < SA_N; j++) begin : g_col
      logic signed [15:0] prod [VEC_W];  // Stage 1 products
      logic               prod_valid;
      logic signed [17:0] prod_sum;      // Four 16-bit terms need 18 bits

      // Stage 1 valid, held while stalled
      always_ff @(posedge clk) begin
        if (reset) begin
          prod_valid <= 1'b0;
        end else if (!stall) begin
          prod_valid <= in_valid;
        end
      end

      // Stage 1 products
      always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
          for (int k = 0; k < VEC_W; k++) begin
            prod[k] <= a_in[i].v[k] * b_in[j].v[k];  // Signed 8x8
          end
        end
      end

      always_comb begin
        prod_sum = '0;
        for (int k = 0; k < VEC_W; k++) begin
          prod_sum = prod_sum + prod[k];
        end
      end

      // Stage 2 accumulate, bias load wins and ignores stall
      always_ff @(posedge clk) begin
        if (load_bias) begin
          acc[i][j] <= bias_value;
        end else if (!stall && prod_valid) begin
          acc[i][j] <= acc[i][j] + prod_sum;  // Wraps at 32 bits
        end
      end

      assign pe_valid[i*SA_N+j] = prod_valid;
    end
  end

  assign sta_idle = ~|pe_valid;  // High once the product stage is empty

  // Bias may only land on a quiet array, never on top of a product
  assert property (@(posedge clk) disable iff (reset)
    load_bias |-> !in_valid && sta_idle)
    else $error("load_bias while array busy or with in_valid");

endmodule

/* source/output_coordinator.sv */
`timescale 1ns/10ps

module output_coordinator import sta_pkg::*; #(
  parameter int MAX_N  = 64,             // Largest matrix dimension
  parameter int N_BITS = $clog2(MAX_N)   // Coordinate width
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              done,
  input  logic              sta_idle,
  input  logic [N_BITS-1:0] pos_row,
  input  logic [N_BITS-1:0] pos_col,
  input  int32_t            acc [SA_N][SA_N],
  output logic [N_BITS-1:0] block_row,  // Position latched at done
  output logic [N_BITS-1:0] block_col,
  output acc_row_t          rows,
  output logic              idle
);

  oc_state_e  state;
  logic [1:0] row_cnt;  // Array row being drained
  logic       accept;

  assign accept = done && !stall && sta_idle && (state == OC_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= OC_IDLE;
      row_cnt <= '0;
    end else begin
      case (state)
        OC_IDLE: if (accept) begin
          state   <= OC_DRAIN;
          row_cnt <= '0;
        end
        OC_DRAIN: if (!stall) begin  // Stall freezes the drain
          row_cnt <= row_cnt + 2'd1;
          if (row_cnt == 2'(SA_N - 1)) state <= OC_IDLE;
        end
        default: state <= OC_IDLE;
      endcase
    end
  end

  // Block position
  always_ff @(posedge clk) begin
    if (accept) begin
      block_row <= pos_row;
      block_col <= pos_col;
    end
  end

  // Row output straight off the accumulators, one row per unstalled cycle
  always_comb begin
    rows.valid = (state == OC_DRAIN) && !stall;
    rows.row   = row_cnt;
    for (int j = 0; j < SA_N; j++) rows.data[j] = acc[row_cnt][j];
  end

  assign idle = (state == OC_IDLE);

  // done is only legal when it can actually be taken
  assert property (@(posedge clk) disable iff (reset)
    done |-> state == OC_IDLE && sta_idle && !stall)
    else $error("done outside an accepting cycle");

endmodule

/* source/requantize_controller.sv */
`timescale 1ns/10ps

module requantize_controller import sta_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [2:0] layer_idx,  // Selects the scale/shift table entry
  input  acc_row_t   in_row,
  output q_row_t     out_row,
  output logic       idle
);

  logic               q_valid;
  logic [1:0]         q_row;
  int8_t [SA_N-1:0]   q_data;
  int8_t [SA_N-1:0]   lane_sat;  // Combinational lane results

  // Clamp a wide signed value to the int8 range
  function automatic int8_t sat8(input logic signed [47:0] x);
    int8_t r;
    if (x > 48'sd127) begin
      r = 8'sd127;
    end else if (x < -48'sd128) begin
      r = -8'sd128;
    end else begin
      r = x[7:0];
    end
    return r;
  endfunction

  always_comb begin
    logic signed [47:0] prod;
    logic signed [47:0] shifted;
    for (int l = 0; l < SA_N; l++) begin
      prod        = in_row.data[l] * layer_scale[layer_idx];  // 32x16 -> 48
      shifted     = prod >>> layer_shift[layer_idx];          // Floors toward -inf
      lane_sat[l] = sat8(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= in_row.valid;
    end
  end

  // Payload follows the valid bit by the same single cycle
  always_ff @(posedge clk) begin
    if (in_row.valid) begin
      q_row  <= in_row.row;
      q_data <= lane_sat;
    end
  end

  assign out_row = '{valid: q_valid, row: q_row, data: q_data};
  assign idle    = !q_valid;

endmodule

/* source/maxpool_unit.sv */
`timescale 1ns/10ps

module maxpool_unit import sta_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  q_row_t    in_row,
  output pool_row_t out_row,
  output logic      idle
);

  logic        held;       // Even row waiting for its partner
  int8_t [1:0] held_max;   // Pair maxima of the even row
  int8_t [1:0] pair_max;   // Pair maxima of the incoming row
  logic        p_valid;
  logic        p_row;
  int8_t [1:0] p_data;
  logic        even_in;
  logic        odd_in;

  function automatic int8_t max8(input int8_t a, input int8_t b);
    return (a > b) ? a : b;
  endfunction

  assign pair_max[0] = max8(in_row.data[0], in_row.data[1]);  // Columns 0,1
  assign pair_max[1] = max8(in_row.data[2], in_row.data[3]);  // Columns 2,3

  assign even_in = in_row.valid && !in_row.row[0];
  assign odd_in  = in_row.valid &&  in_row.row[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      held    <= 1'b0;
      p_valid <= 1'b0;
    end else begin
      p_valid <= odd_in;
      if (even_in) held <= 1'b1;
      else if (odd_in) held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (even_in) held_max <= pair_max;
    if (odd_in) begin
      p_row     <= in_row.row[1];  // Rows 0,1 -> 0 and 2,3 -> 1
      p_data[0] <= max8(held_max[0], pair_max[0]);
      p_data[1] <= max8(held_max[1], pair_max[1]);
    end
  end

  assign out_row = '{valid: p_valid, row: p_row, data: p_data};
  assign idle    = !held && !p_valid;

  // Rows come in pairs, an odd row never shows up on its own
  assert property (@(posedge clk) disable iff (reset)
    odd_in |-> held)
    else $error("odd row without a held even row");

endmodule

/* source/sta_controller.sv */
`timescale 1ns/10ps

module sta_controller import sta_pkg::*; #(
  parameter int MAX_N  = 64,             // Largest matrix dimension
  parameter int N_BITS = $clog2(MAX_N)   // Coordinate width
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              bypass_maxpool,  // Pack one raw block instead of four pooled
  input  logic [2:0]        layer_idx,
  input  logic [N_BITS-1:0] pos_row,
  input  logic [N_BITS-1:0] pos_col,
  input  logic              load_bias,
  input  int32_t            bias_value,
  input  sta_vec_t          a_in [SA_N],     // Already skewed by the caller
  input  sta_vec_t          b_in [SA_N],
  input  logic              in_valid,
  input  logic              done,
  output logic              idle,
  output logic              sta_idle,
  output logic              array_out_valid,
  output logic [127:0]      array_val_out,
  output logic [N_BITS-1:0] array_row_out,
  output logic [N_BITS-1:0] array_col_out
);

  int32_t            acc [SA_N][SA_N];
  logic [N_BITS-1:0] blk_row, blk_col;
  acc_row_t          acc_row;
  q_row_t            q_row;
  pool_row_t         p_row;
  logic              oc_idle, rq_idle, mp_idle;
  buf_mode_e         mode;

  int8_t                out_buf [SA_N][SA_N];
  logic [SA_N*SA_N-1:0] buf_valid;   // Index r*SA_N+c
  logic [1:0]           chunk;       // TL, TR, BL, BR
  logic                 chunk_done;
  logic                 all_valid;
  logic                 buf_wr;
  logic [N_BITS-1:0]    first_row, first_col;  // Position of chunk 0

  systolic_tensor_array u_array (
    .clk, .reset, .stall, .in_valid, .a_in, .b_in, .load_bias, .bias_value,
    .acc, .sta_idle
  );

  output_coordinator #(.MAX_N(MAX_N), .N_BITS(N_BITS)) u_coord (
    .clk, .reset, .stall, .done, .sta_idle, .pos_row, .pos_col, .acc,
    .block_row(blk_row), .block_col(blk_col), .rows(acc_row), .idle(oc_idle)
  );

  requantize_controller u_requant (
    .clk, .reset, .layer_idx, .in_row(acc_row), .out_row(q_row), .idle(rq_idle)
  );

  maxpool_unit u_pool (
    .clk, .reset, .in_row(q_row), .out_row(p_row), .idle(mp_idle)
  );

  assign mode      = bypass_maxpool ? BUF_BYPASS : BUF_POOL;
  assign all_valid = &buf_valid;
  assign buf_wr    = (mode == BUF_BYPASS) ? q_row.valid : p_row.valid;

  // Current 2x2 chunk full
  always_comb begin
    chunk_done = 1'b1;
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < 2; c++) begin
        chunk_done &= buf_valid[(chunk[1]*2 + r)*SA_N + chunk[0]*2 + c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_valid       <= '0;
      chunk           <= '0;
      array_out_valid <= 1'b0;
    end else begin
      array_out_valid <= all_valid;  // Single pulse, valid bits clear on the same edge
      if (all_valid) begin
        buf_valid <= '0;
        chunk     <= '0;
      end else if (mode == BUF_BYPASS) begin
        if (q_row.valid) begin
          for (int c = 0; c < SA_N; c++) buf_valid[q_row.row*SA_N + c] <= 1'b1;
        end
      end else begin
        if (p_row.valid) begin
          for (int c = 0; c < 2; c++) begin
            buf_valid[(chunk[1]*2 + p_row.row)*SA_N + chunk[0]*2 + c] <= 1'b1;
          end
        end
        if (chunk_done) chunk <= chunk + 2'd1;
      end
    end
  end

  // Buffer data and the packed word
  always_ff @(posedge clk) begin
    if (mode == BUF_BYPASS && q_row.valid) begin
      for (int c = 0; c < SA_N; c++) out_buf[q_row.row][c] <= q_row.data[c];
    end
    if (mode == BUF_POOL && p_row.valid) begin
      for (int c = 0; c < 2; c++) out_buf[chunk[1]*2 + p_row.row][chunk[0]*2 + c] <= p_row.data[c];
    end
    if (buf_wr && buf_valid == '0) begin  // First write of a new word
      first_row <= blk_row;
      first_col <= blk_col;
    end
    if (all_valid) begin
      // MSB first, chunks TL TR BL BR, each chunk [0][0] [0][1] [1][0] [1][1]
      for (int ch = 0; ch < 4; ch++) begin
        for (int k = 0; k < 4; k++) begin
          array_val_out[127 - (ch*4 + k)*8 -: 8] <= out_buf[(ch/2)*2 + k/2][(ch%2)*2 + k%2];
        end
      end
      array_row_out <= first_row;
      array_col_out <= first_col;
    end
  end

  assign idle = sta_idle & oc_idle & rq_idle & mp_idle;

endmodule

/* testbench/sta_tb.sv */
`timescale 1ns/10ps

module sta_tb import sta_pkg::*; ();

  localparam int MAX_N  = 64;
  localparam int N_BITS = $clog2(MAX_N);

  // One expected output word
  typedef struct packed {
    logic [127:0]      word;
    logic [N_BITS-1:0] row;
    logic [N_BITS-1:0] col;
  } exp_word_t;

  logic              clk;
  logic              reset;
  logic              stall;
  logic              bypass_maxpool;
  logic [2:0]        layer_idx;
  logic [N_BITS-1:0] pos_row;
  logic [N_BITS-1:0] pos_col;
  logic              load_bias;
  int32_t            bias_value;
  sta_vec_t          a_in [SA_N];
  sta_vec_t          b_in [SA_N];
  logic              in_valid;
  logic              done;
  logic              idle;
  logic              sta_idle;
  logic              array_out_valid;
  logic [127:0]      array_val_out;
  logic [N_BITS-1:0] array_row_out;
  logic [N_BITS-1:0] array_col_out;

  logic [31:0]       lfsr;                 // Galois LFSR state
  logic              use_stall;            // Random stall levels on
  logic              busy_m;               // Model product stage holds an input
  int                acc_m [SA_N][SA_N];   // Model accumulators
  exp_word_t         exp_q [$];            // Scoreboard, oldest first
  exp_word_t         exp_head;
  logic [127:0]      pool_word;            // Pooled word being built
  logic [N_BITS-1:0] pool_row0;            // Position of the first pooled block
  logic [N_BITS-1:0] pool_col0;
  int                pool_cnt;             // Pooled blocks in pool_word
  int                mismatch_cnt;
  int                other_cnt;
  int                sat_hi;               // Model clamps at +127
  int                sat_lo;               // Model clamps at -128

  sta_controller #(.MAX_N(MAX_N), .N_BITS(N_BITS)) dut0 (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  // n fresh bits with one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int small_bias();
    return int'(rand_bits(14)) - 8192;  // Range -8192..8191
  endfunction

  // Scale, floor shift and clamp to int8
  function automatic logic signed [7:0] requant(input int v, input int layer);
    longint p;
    logic signed [7:0] q;
    p = longint'(v) * longint'(layer_scale[layer]);
    p = p >>> layer_shift[layer];  // Floor toward minus infinity
    if (p > 127) begin
      q = 8'sd127;
      sat_hi++;
    end else if (p < -128) begin
      q = -8'sd128;
      sat_lo++;
    end else begin
      q = p[7:0];
    end
    return q;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive and sample just after the edge
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    other_cnt++;
    $display("Timeout at %0t waiting for %s", $time, what);
    report_and_finish();
  endtask

  // sta_idle is high once no accepted input is left in the product stage
  task automatic check_sta_idle();
    if (sta_idle !== !busy_m) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: sta_idle %b, expected %b", $time, sta_idle, !busy_m);
    end
  endtask

  // Dot products of one accepted input cycle
  task automatic accumulate();
    for (int i = 0; i < SA_N; i++)
      for (int j = 0; j < SA_N; j++)
        for (int k = 0; k < VEC_W; k++)
          acc_m[i][j] += int'(a_in[i].v[k]) * int'(b_in[j].v[k]);  // Wraps like int32
  endtask

  // Expected result of one drained block
  task automatic model_block(input int layer, input logic [N_BITS-1:0] prow,
                             input logic [N_BITS-1:0] pcol);
    logic signed [7:0] q [SA_N][SA_N];
    logic signed [7:0] m;
    logic [127:0]      w;
    for (int i = 0; i < SA_N; i++)
      for (int j = 0; j < SA_N; j++)
        q[i][j] = requant(acc_m[i][j], layer);
    if (bypass_maxpool) begin
      w = '0;
      for (int i = 0; i < SA_N; i++)
        for (int j = 0; j < SA_N; j++)  // Byte slot is quadrant*4 + place in quadrant
          w[127 - (((i/2)*2 + j/2)*4 + (i%2)*2 + j%2)*8 -: 8] = q[i][j];
      exp_q.push_back(exp_word_t'{word: w, row: prow, col: pcol});
    end else begin
      if (pool_cnt == 0) begin
        pool_word = '0;
        pool_row0 = prow;
        pool_col0 = pcol;
      end
      for (int r = 0; r < 2; r++) begin
        for (int c = 0; c < 2; c++) begin
          m = q[2*r][2*c];  // Max over the 2x2 window
          if (q[2*r][2*c+1] > m) m = q[2*r][2*c+1];
          if (q[2*r+1][2*c] > m) m = q[2*r+1][2*c];
          if (q[2*r+1][2*c+1] > m) m = q[2*r+1][2*c+1];
          pool_word[127 - (pool_cnt*4 + r*2 + c)*8 -: 8] = m;
        end
      end
      pool_cnt++;
      if (pool_cnt == 4) begin
        exp_q.push_back(exp_word_t'{word: pool_word, row: pool_row0, col: pool_col0});
        pool_cnt = 0;
      end
    end
  endtask

  task automatic wait_sta_idle();
    int cnt;
    cnt = 0;
    while (!sta_idle && cnt < 100) begin
      stall = use_stall && (rand_bits(2) == 0);
      if (!stall) busy_m = 1'b0;  // Product stage empties on an unstalled edge
      next_cycle();
      check_sta_idle();
      cnt++;
    end
    if (!sta_idle) fail_timeout("the array to go idle");
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (!idle && cnt < 200) begin
      stall = use_stall && (rand_bits(2) == 0);  // Stall may pause the drain
      next_cycle();
      cnt++;
    end
    stall = 1'b0;
    if (!idle) fail_timeout("the engine to go idle");
  endtask

  // Scoreboard empty, then the engine must be idle
  task automatic wait_word();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < 50) begin
      next_cycle();
      cnt++;
    end
    if (exp_q.size() != 0) begin
      fail_timeout("an output word");
    end else if (idle !== 1'b1) begin
      other_cnt++;
      $display("idle is not high at %0t after a word was delivered", $time);
    end
  endtask

  // Bias, an input burst, done, then the drain
  task automatic run_block(input int layer, input int bias, input int n_cyc);
    logic [N_BITS-1:0] prow;
    logic [N_BITS-1:0] pcol;
    prow       = rand_bits(N_BITS);
    pcol       = rand_bits(N_BITS);
    layer_idx  = 3'(layer);  // Held through the drain
    load_bias  = 1'b1;
    bias_value = bias;
    stall      = 1'b0;
    for (int i = 0; i < SA_N; i++)
      for (int j = 0; j < SA_N; j++)
        acc_m[i][j] = bias;
    next_cycle();
    load_bias = 1'b0;
    busy_m    = 1'b0;  // The bias cycle carries no input
    for (int n = 0; n < n_cyc; n++) begin
      in_valid = (rand_bits(2) != 0);
      stall    = use_stall && (rand_bits(2) == 0);
      for (int i = 0; i < SA_N; i++) begin
        a_in[i] = sta_vec_t'(rand_bits(32));
        b_in[i] = sta_vec_t'(rand_bits(32));
      end
      if (in_valid && !stall) accumulate();  // Stalled inputs are dropped
      if (!stall) busy_m = in_valid;         // Product stage loads on unstalled edges
      next_cycle();
      check_sta_idle();
    end
    in_valid = 1'b0;
    wait_sta_idle();
    stall   = 1'b0;
    done    = 1'b1;
    pos_row = prow;
    pos_col = pcol;
    next_cycle();
    done = 1'b0;
    model_block(layer, prow, pcol);
    wait_idle();
  endtask

  // Compare each output pulse with the oldest expected word
  always @(negedge clk) begin
    if (!reset && array_out_valid) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("Output word at %0t with no block pending", $time);
      end else begin
        exp_head = exp_q.pop_front();
        if (array_val_out !== exp_head.word) begin
          mismatch_cnt++;
          $display("Mismatch at %0t: word %h, expected %h", $time, array_val_out,
                   exp_head.word);
        end
        if (array_row_out !== exp_head.row || array_col_out !== exp_head.col) begin
          mismatch_cnt++;
          $display("Mismatch at %0t: position %0d,%0d, expected %0d,%0d", $time,
                   array_row_out, array_col_out, exp_head.row, exp_head.col);
        end
      end
    end
  end

  initial begin
    lfsr           = 32'd34;
    reset          = 1'b1;
    stall          = 1'b0;
    bypass_maxpool = 1'b1;
    layer_idx      = '0;
    pos_row        = '0;
    pos_col        = '0;
    load_bias      = 1'b0;
    bias_value     = '0;
    in_valid       = 1'b0;
    done           = 1'b0;
    for (int i = 0; i < SA_N; i++) begin
      a_in[i] = '0;
      b_in[i] = '0;
    end
    use_stall    = 1'b0;
    busy_m       = 1'b0;
    pool_word    = '0;
    pool_row0    = '0;
    pool_col0    = '0;
    pool_cnt     = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    sat_hi       = 0;
    sat_lo       = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    if (array_out_valid !== 1'b0 || idle !== 1'b1) begin
      other_cnt++;
      $display("After reset array_out_valid is not low or idle is not high");
    end

    repeat (6) begin  // Bypass mode gives one word per block
      run_block(int'(rand_bits(3)), small_bias(), 4 + int'(rand_bits(3)));
      wait_word();
    end

    bypass_maxpool = 1'b0;
    repeat (3) begin  // Pool mode takes four blocks per word
      repeat (4) run_block(int'(rand_bits(3)), small_bias(), 4 + int'(rand_bits(3)));
      wait_word();
    end

    bypass_maxpool = 1'b1;
    sat_hi = 0;
    sat_lo = 0;
    for (int l = 0; l < NUM_LAYERS; l++) begin  // Large biases on both sides
      run_block(l, int'(32'h4000_0000 | rand_bits(28)), 3);
      wait_word();
      run_block(l, int'(32'hC000_0000 | rand_bits(28)), 3);
      wait_word();
    end
    if (sat_hi == 0 || sat_lo == 0) begin
      other_cnt++;
      $display("Requantization sweep did not reach both int8 limits");
    end

    use_stall = 1'b1;
    repeat (4) begin
      run_block(int'(rand_bits(3)), small_bias(), 6 + int'(rand_bits(3)));
      wait_word();
    end
    bypass_maxpool = 1'b0;
    repeat (2) begin
      repeat (4) run_block(int'(rand_bits(3)), small_bias(), 6 + int'(rand_bits(3)));
      wait_word();
    end
    use_stall = 1'b0;

    repeat (10) next_cycle();  // Quiet time in which no stray word may appear
    report_and_finish();
  end

endmodule

/* sta_controller.f */
source/sta_pkg.sv
source/systolic_tensor_array.sv
source/output_coordinator.sv
source/requantize_controller.sv
source/maxpool_unit.sv
source/sta_controller.sv
testbench/sta_tb.sv

/* Makefile */
TOP = sta_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module sta_controller -f sta_controller.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sta_controller.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG)
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
